//--- rtl/csr_access_decode.sv
`include "csr_config.svh"

module csr_access_decode import csr_addr_pkg::*; (
    input  logic                   software_en,
    input  logic [`CSR_ADDR_W-1:0] addr,
    input  logic                   wen,
    input  logic [`CSR_DATA_W-1:0] crmd_val,
    input  logic [`CSR_DATA_W-1:0] prmd_val,
    input  logic [`CSR_DATA_W-1:0] ecfg_val,
    input  logic [`CSR_DATA_W-1:0] estat_val,
    input  logic [`CSR_DATA_W-1:0] era_val,
    input  logic [`CSR_DATA_W-1:0] badv_val,
    input  logic [`CSR_DATA_W-1:0] eentry_val,
    input  logic [`CSR_DATA_W-1:0] save_val [4],
    input  logic [`CSR_DATA_W-1:0] tid_val,
    input  logic [`CSR_DATA_W-1:0] tcfg_val,
    input  logic [`CSR_DATA_W-1:0] tval_val,
    output logic                   crmd_we,
    output logic                   prmd_we,
    output logic                   ecfg_we,
    output logic                   estat_we,
    output logic                   era_we,
    output logic                   badv_we,
    output logic                   eentry_we,
    output logic [3:0]             save_we,
    output logic                   tid_we,
    output logic                   tcfg_we,
    output logic                   ticlr_we,
    output logic [`CSR_DATA_W-1:0] rdata
);

    logic acc;

    assign acc = software_en && wen;

    // One compare per address feeds both the strobe and the read mux
    always_comb begin
        crmd_we   = 1'b0;
        prmd_we   = 1'b0;
        ecfg_we   = 1'b0;
        estat_we  = 1'b0;
        era_we    = 1'b0;
        badv_we   = 1'b0;
        eentry_we = 1'b0;
        save_we   = 4'b0;
        tid_we    = 1'b0;
        tcfg_we   = 1'b0;
        ticlr_we  = 1'b0;
        rdata     = '0;
        case (addr)
            ADDR_CRMD:   begin crmd_we   = acc; rdata = crmd_val;   end
            ADDR_PRMD:   begin prmd_we   = acc; rdata = prmd_val;   end
            ADDR_ECFG:   begin ecfg_we   = acc; rdata = ecfg_val;   end
            ADDR_ESTAT:  begin estat_we  = acc; rdata = estat_val;  end
            ADDR_ERA:    begin era_we    = acc; rdata = era_val;    end
            ADDR_BADV:   begin badv_we   = acc; rdata = badv_val;   end
            ADDR_EENTRY: begin eentry_we = acc; rdata = eentry_val; end
            ADDR_SAVE0:  begin save_we[0] = acc; rdata = save_val[0]; end
            ADDR_SAVE1:  begin save_we[1] = acc; rdata = save_val[1]; end
            ADDR_SAVE2:  begin save_we[2] = acc; rdata = save_val[2]; end
            ADDR_SAVE3:  begin save_we[3] = acc; rdata = save_val[3]; end
            ADDR_TID:    begin tid_we    = acc; rdata = tid_val;    end
            ADDR_TCFG:   begin tcfg_we   = acc; rdata = tcfg_val;   end
            ADDR_TVAL:   rdata = tval_val;
            // Write-only clear, reads as zero
            ADDR_TICLR:  ticlr_we = acc;
            default:     rdata = '0;
        endcase
    end

endmodule

//--- rtl/csr_addr_pkg.sv
`include "csr_config.svh"

package csr_addr_pkg;

    // Kept CSR numbers
    typedef enum logic [`CSR_ADDR_W-1:0] {
        ADDR_CRMD   = 14'h000,
        ADDR_PRMD   = 14'h001,
        ADDR_ECFG   = 14'h004,
        ADDR_ESTAT  = 14'h005,
        ADDR_ERA    = 14'h006,
        ADDR_BADV   = 14'h007,
        ADDR_EENTRY = 14'h00c,
        ADDR_SAVE0  = 14'h030,
        ADDR_SAVE1  = 14'h031,
        ADDR_SAVE2  = 14'h032,
        ADDR_SAVE3  = 14'h033,
        // Timer group
        ADDR_TID    = 14'h040,
        ADDR_TCFG   = 14'h041,
        ADDR_TVAL   = 14'h042,
        ADDR_TICLR  = 14'h044
    } csr_addr_e;

endpackage

//--- rtl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Datapath widths
`define CSR_DATA_W      32
`define CSR_ADDR_W      14

// Interrupt lines from outside the core
`define CSR_HWI_W       8

// Exception code, and code plus subcode bit as delivered by the pipeline
`define CSR_ECODE_W     6
`define CSR_EXPCODE_W   7

// TCFG.InitVal width
`define CSR_TIMER_W     30

// Direct address mode after reset
`define CSR_CRMD_RESET  32'h0000_0008

`endif

//--- rtl/csr_field_pkg.sv
`include "csr_config.svh"

package csr_field_pkg;

    // CRMD
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_PLV_HI    = 1;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF_LO   = 5;
    localparam int CRMD_DATF_HI   = 6;
    localparam int CRMD_DATM_LO   = 7;
    localparam int CRMD_DATM_HI   = 8;

    // PRMD
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PPLV_HI   = 1;
    localparam int PRMD_PIE       = 2;

    // ESTAT
    localparam int ESTAT_SOFT_LO  = 0;
    localparam int ESTAT_SOFT_HI  = 1;
    localparam int ESTAT_HARD_LO  = 2;
    localparam int ESTAT_HARD_HI  = 9;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_IS_W     = 13;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ESUBCODE = 22;

    // Writable bits of ECFG.LIE and EENTRY.VA
    localparam logic [`CSR_DATA_W-1:0] ECFG_LIE_MASK  = 32'h0000_1bff;
    localparam logic [`CSR_DATA_W-1:0] EENTRY_VA_MASK = 32'hffff_ffc0;

    // TCFG
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;

    typedef enum logic [`CSR_ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_PIL = 6'h01,
        ECODE_PIS = 6'h02,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

endpackage

//--- rtl/csr_top.sv
`include "csr_config.svh"

module csr_top import csr_field_pkg::*; (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      software_en,
    input  logic [`CSR_ADDR_W-1:0]    addr,
    input  logic                      wen,
    input  logic [`CSR_DATA_W-1:0]    wdata,
    output logic [`CSR_DATA_W-1:0]    rdata,
    input  logic                      exception,
    input  logic                      ertn,
    input  logic [`CSR_EXPCODE_W-1:0] expcode_in,
    input  logic                      wen_expcode,
    input  logic [`CSR_DATA_W-1:0]    era_in,
    input  logic                      wen_era,
    input  logic [`CSR_DATA_W-1:0]    badv_in,
    input  logic                      wen_badv,
    input  logic [`CSR_HWI_W-1:0]     hardware_interrupt,
    output logic [`CSR_DATA_W-1:0]    crmd,
    output logic [`CSR_DATA_W-1:0]    estat,
    output logic [`CSR_DATA_W-1:0]    era_out,
    output logic [`CSR_DATA_W-1:0]    eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over,
    output logic [`CSR_DATA_W-1:0]    tid
);

    logic crmd_we, prmd_we, ecfg_we, estat_we, era_we, badv_we;
    logic eentry_we, tid_we, tcfg_we, ticlr_we;
    logic [3:0] save_we;

    logic [`CSR_DATA_W-1:0]  prmd_val, ecfg_val, badv_val, tcfg_val, tval_val;
    logic [`CSR_DATA_W-1:0]  save_val [4];
    logic [`CSR_ECODE_W-1:0] ecode;
    logic                    esubcode;
    logic                    timer_irq;

    csr_access_decode u_decode (
        .software_en(software_en), .addr(addr), .wen(wen),
        .crmd_val(crmd), .prmd_val(prmd_val), .ecfg_val(ecfg_val),
        .estat_val(estat), .era_val(era_out), .badv_val(badv_val),
        .eentry_val(eentry), .save_val(save_val), .tid_val(tid),
        .tcfg_val(tcfg_val), .tval_val(tval_val),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we),
        .estat_we(estat_we), .era_we(era_we), .badv_we(badv_we),
        .eentry_we(eentry_we), .save_we(save_we), .tid_we(tid_we),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we), .rdata(rdata)
    );

    trap_ctrl u_trap (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .era_we(era_we), .badv_we(badv_we),
        .exception(exception), .ertn(ertn),
        .expcode_in(expcode_in), .wen_expcode(wen_expcode),
        .era_in(era_in), .wen_era(wen_era), .badv_in(badv_in), .wen_badv(wen_badv),
        .crmd_val(crmd), .prmd_val(prmd_val), .era_val(era_out), .badv_val(badv_val),
        .ecode(ecode), .esubcode(esubcode)
    );

    irq_status u_irq (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .ecfg_we(ecfg_we), .estat_we(estat_we),
        .hardware_interrupt(hardware_interrupt), .timer_irq(timer_irq),
        .ie(crmd[CRMD_IE]), .ecode(ecode), .esubcode(esubcode),
        .ecfg_val(ecfg_val), .estat_val(estat),
        .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    stable_timer u_timer (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we),
        .tcfg_val(tcfg_val), .tval_val(tval_val), .timer_irq(timer_irq)
    );

    save_regs u_save (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .eentry_we(eentry_we), .save_we(save_we), .tid_we(tid_we),
        .eentry_val(eentry), .save_val(save_val), .tid_val(tid)
    );

endmodule

//--- rtl/irq_status.sv
`include "csr_config.svh"

module irq_status import csr_field_pkg::*; (
    input  logic                    clk,
    input  logic                    aresetn,
    input  logic [`CSR_DATA_W-1:0]  wdata,
    input  logic                    ecfg_we,
    input  logic                    estat_we,
    input  logic [`CSR_HWI_W-1:0]   hardware_interrupt,
    input  logic                    timer_irq,
    input  logic                    ie,
    input  logic [`CSR_ECODE_W-1:0] ecode,
    input  logic                    esubcode,
    output logic [`CSR_DATA_W-1:0]  ecfg_val,
    output logic [`CSR_DATA_W-1:0]  estat_val,
    output logic                    cpu_interrupt,
    output logic                    idle_over
);

    logic [1:0] soft_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_val <= '0;
            soft_q   <= 2'b0;
        end else begin
            if (ecfg_we) begin
                ecfg_val <= wdata & ECFG_LIE_MASK;
            end
            if (estat_we) begin
                soft_q <= wdata[ESTAT_SOFT_HI:ESTAT_SOFT_LO];
            end
        end
    end

    // Hardware lines pass straight through, no latching
    always_comb begin
        estat_val = '0;
        estat_val[ESTAT_SOFT_HI:ESTAT_SOFT_LO]   = soft_q;
        estat_val[ESTAT_HARD_HI:ESTAT_HARD_LO]   = hardware_interrupt;
        estat_val[ESTAT_TI]                      = timer_irq;
        estat_val[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = ecode;
        estat_val[ESTAT_ESUBCODE]                = esubcode;
    end

    assign cpu_interrupt = ie && |(ecfg_val[ESTAT_IS_W-1:0] & estat_val[ESTAT_IS_W-1:0]);
    // Wakeup ignores both enables
    assign idle_over     = |estat_val[ESTAT_IS_W-1:0];

endmodule

//--- rtl/save_regs.sv
`include "csr_config.svh"

module save_regs import csr_field_pkg::*; (
    input  logic                   clk,
    input  logic                   aresetn,
    input  logic [`CSR_DATA_W-1:0] wdata,
    input  logic                   eentry_we,
    input  logic [3:0]             save_we,
    input  logic                   tid_we,
    output logic [`CSR_DATA_W-1:0] eentry_val,
    output logic [`CSR_DATA_W-1:0] save_val [4],
    output logic [`CSR_DATA_W-1:0] tid_val
);

    // Entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            eentry_val <= '0;
        end else if (eentry_we) begin
            eentry_val <= wdata & EENTRY_VA_MASK;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!aresetn) begin
                save_val[i] <= '0;
            end else if (save_we[i]) begin
                save_val[i] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tid_val <= '0;
        end else if (tid_we) begin
            tid_val <= wdata;
        end
    end

endmodule

//--- rtl/stable_timer.sv
`include "csr_config.svh"

module stable_timer import csr_field_pkg::*; (
    input  logic                   clk,
    input  logic                   aresetn,
    input  logic [`CSR_DATA_W-1:0] wdata,
    input  logic                   tcfg_we,
    input  logic                   ticlr_we,
    output logic [`CSR_DATA_W-1:0] tcfg_val,
    output logic [`CSR_DATA_W-1:0] tval_val,
    output logic                   timer_irq
);

    logic [`CSR_TIMER_W-1:0] initval;
    logic                    set_timer;
    logic                    time_out;

    assign initval = tcfg_val[TCFG_INITVAL_HI:TCFG_INITVAL_LO];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_val  <= '0;
            set_timer <= 1'b0;
        end else begin
            if (tcfg_we) begin
                tcfg_val <= wdata;
            end
            set_timer <= tcfg_we;
        end
    end

    // Load value is initval*4+1 so that initval 0 still fires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_val <= '0;
            time_out <= 1'b0;
        end else if (set_timer || tval_val == '0) begin
            time_out <= 1'b0;
            if (set_timer || tcfg_val[TCFG_PERIODIC]) begin
                tval_val <= {initval, 2'b01};
            end
        end else if (tcfg_val[TCFG_EN]) begin
            tval_val <= tval_val - 1'b1;
            time_out <= (tval_val == 1);
        end
    end

    // Sticky until software clears it
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_irq <= 1'b0;
        end else if (ticlr_we) begin
            timer_irq <= 1'b0;
        end else if (time_out) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

//--- rtl/trap_ctrl.sv
`include "csr_config.svh"

module trap_ctrl import csr_field_pkg::*; (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic [`CSR_DATA_W-1:0]    wdata,
    input  logic                      crmd_we,
    input  logic                      prmd_we,
    input  logic                      era_we,
    input  logic                      badv_we,
    input  logic                      exception,
    input  logic                      ertn,
    input  logic [`CSR_EXPCODE_W-1:0] expcode_in,
    input  logic                      wen_expcode,
    input  logic [`CSR_DATA_W-1:0]    era_in,
    input  logic                      wen_era,
    input  logic [`CSR_DATA_W-1:0]    badv_in,
    input  logic                      wen_badv,
    output logic [`CSR_DATA_W-1:0]    crmd_val,
    output logic [`CSR_DATA_W-1:0]    prmd_val,
    output logic [`CSR_DATA_W-1:0]    era_val,
    output logic [`CSR_DATA_W-1:0]    badv_val,
    output logic [`CSR_ECODE_W-1:0]   ecode,
    output logic                      esubcode
);

    logic [2:0] prmd_q;
    logic       pair_ok;

    // Only DA=1/PG=0 or DA=0/PG=1 is a legal translation mode
    assign pair_ok = wdata[CRMD_DA] ^ wdata[CRMD_PG];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_val <= `CSR_CRMD_RESET;
        end else if (ertn) begin
            crmd_val[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd_q[PRMD_PPLV_HI:PRMD_PPLV_LO];
            crmd_val[CRMD_IE]                 <= prmd_q[PRMD_PIE];
        end else if (exception) begin
            crmd_val[CRMD_PLV_HI:CRMD_PLV_LO] <= 2'd0;
            crmd_val[CRMD_IE]                 <= 1'b0;
        end else if (crmd_we) begin
            crmd_val[CRMD_PLV_HI:CRMD_PLV_LO]   <= wdata[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_val[CRMD_IE]                   <= wdata[CRMD_IE];
            crmd_val[CRMD_DATF_HI:CRMD_DATF_LO] <= wdata[CRMD_DATF_HI:CRMD_DATF_LO];
            crmd_val[CRMD_DATM_HI:CRMD_DATM_LO] <= wdata[CRMD_DATM_HI:CRMD_DATM_LO];
            if (pair_ok) begin
                crmd_val[CRMD_DA] <= wdata[CRMD_DA];
                crmd_val[CRMD_PG] <= wdata[CRMD_PG];
            end
        end
    end

    // Previous mode saved on trap entry
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_q <= 3'b0;
        end else if (exception) begin
            prmd_q[PRMD_PPLV_HI:PRMD_PPLV_LO] <= crmd_val[CRMD_PLV_HI:CRMD_PLV_LO];
            prmd_q[PRMD_PIE]                  <= crmd_val[CRMD_IE];
        end else if (prmd_we) begin
            prmd_q <= wdata[PRMD_PIE:PRMD_PPLV_LO];
        end
    end

    assign prmd_val = {{(`CSR_DATA_W-3){1'b0}}, prmd_q};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_val <= '0;
        end else if (wen_era) begin
            era_val <= era_in;
        end else if (era_we) begin
            era_val <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            badv_val <= '0;
        end else if (wen_badv) begin
            badv_val <= badv_in;
        end else if (badv_we) begin
            badv_val <= wdata;
        end
    end

    // Subcode only meaningful for a nonzero code
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecode    <= '0;
            esubcode <= 1'b0;
        end else if (wen_expcode) begin
            ecode    <= expcode_in[`CSR_ECODE_W-1:0];
            esubcode <= (expcode_in[`CSR_ECODE_W-1:0] == ECODE_INT) ?
                        1'b0 : expcode_in[`CSR_EXPCODE_W-1];
        end
    end

endmodule

//--- test/csr_tb.sv
`include "csr_config.svh"

module csr_tb import csr_addr_pkg::*, csr_field_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TBL_N      = 9;
    localparam int TIMER_INIT = 3;
    localparam int TI_LIMIT   = 64;

    logic                      clk;
    logic                      aresetn;
    logic                      software_en;
    logic [`CSR_ADDR_W-1:0]    addr;
    logic                      wen;
    logic [`CSR_DATA_W-1:0]    wdata;
    logic [`CSR_DATA_W-1:0]    rdata;
    logic                      exception;
    logic                      ertn;
    logic [`CSR_EXPCODE_W-1:0] expcode_in;
    logic                      wen_expcode;
    logic [`CSR_DATA_W-1:0]    era_in;
    logic                      wen_era;
    logic [`CSR_DATA_W-1:0]    badv_in;
    logic                      wen_badv;
    logic [`CSR_HWI_W-1:0]     hardware_interrupt;
    logic [`CSR_DATA_W-1:0]    crmd;
    logic [`CSR_DATA_W-1:0]    estat;
    logic [`CSR_DATA_W-1:0]    era_out;
    logic [`CSR_DATA_W-1:0]    eentry;
    logic                      cpu_interrupt;
    logic                      idle_over;
    logic [`CSR_DATA_W-1:0]    tid;

    logic [31:0] lfsr_state;
    int          err_cnt;
    int          err_at_start;
    int          tests_ok;
    int          tests_bad;
    string       cur_test;

    // Write/read-back table with the writable bits of each register
    csr_addr_e   tbl_addr [TBL_N] = '{ADDR_SAVE0, ADDR_SAVE1, ADDR_SAVE2, ADDR_SAVE3,
                                      ADDR_TID, ADDR_ERA, ADDR_BADV, ADDR_EENTRY, ADDR_ECFG};
    logic [31:0] tbl_mask [TBL_N] = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
                                      32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
                                      32'hffff_ffff, 32'hffff_ffc0, 32'h0000_1bff};

    csr_top uut (.*);

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Fields 8:0 follow the write unless the DA/PG pair is illegal
    function automatic logic [31:0] crmd_expect(input logic [31:0] old, input logic [31:0] w);
        logic [31:0] r;
        r = w & 32'h0000_01ff;
        if (w[CRMD_DA] == w[CRMD_PG]) begin
            r[CRMD_PG:CRMD_DA] = old[CRMD_PG:CRMD_DA];
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic write_csr(input csr_addr_e a, input logic [31:0] d);
        @(negedge clk);
        software_en = 1'b1;
        wen         = 1'b1;
        addr        = a;
        wdata       = d;
        @(negedge clk);
        wen         = 1'b0;
        software_en = 1'b0;
    endtask

    task automatic check_reg(input csr_addr_e a, input logic [31:0] exp);
        @(negedge clk);
        addr = a;
        #5;
        check_val(a.name(), exp, rdata);
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == err_at_start) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, err_cnt - err_at_start);
        end
    endtask

    initial begin
        csr_addr_e   a;
        logic [31:0] w;
        logic [31:0] exp_crmd;
        logic [1:0]  pg_da [4];
        logic [7:0]  hw;
        int          n;

        clk = 1'b0;
        aresetn = 1'b0;
        software_en = 1'b0;
        addr = '0;
        wen = 1'b0;
        wdata = '0;
        exception = 1'b0;
        ertn = 1'b0;
        expcode_in = '0;
        wen_expcode = 1'b0;
        era_in = '0;
        wen_era = 1'b0;
        badv_in = '0;
        wen_badv = 1'b0;
        hardware_interrupt = '0;
        lfsr_state = 32'h734d9787;
        err_cnt = 0;
        tests_ok = 0;
        tests_bad = 0;
        pg_da = '{2'b11, 2'b00, 2'b10, 2'b01};

        repeat (10) @(negedge clk);
        aresetn = 1'b1;

        start_test("reset values");
        a = a.first();
        repeat (a.num()) begin
            check_reg(a, (a == ADDR_CRMD) ? `CSR_CRMD_RESET : 32'h0);
            a = a.next();
        end
        check_val("cpu_interrupt", 0, cpu_interrupt);
        check_val("idle_over", 0, idle_over);
        finish_test();

        start_test("write and read back");
        for (int i = 0; i < TBL_N; i++) begin
            w = next_bits(32);
            write_csr(tbl_addr[i], w);
            check_reg(tbl_addr[i], w & tbl_mask[i]);
            if (tbl_addr[i] == ADDR_EENTRY) begin
                check_val("eentry", w & tbl_mask[i], eentry);
            end else if (tbl_addr[i] == ADDR_TID) begin
                check_val("tid", w, tid);
            end
        end
        finish_test();

        start_test("crmd da/pg pair");
        exp_crmd = `CSR_CRMD_RESET;
        for (int i = 0; i < 4; i++) begin
            w = next_bits(32);
            w[CRMD_PG:CRMD_DA] = pg_da[i];
            write_csr(ADDR_CRMD, w);
            exp_crmd = crmd_expect(exp_crmd, w);
            check_reg(ADDR_CRMD, exp_crmd);
        end
        finish_test();

        start_test("exception and return");
        write_csr(ADDR_CRMD, 32'h0000_000f);
        check_reg(ADDR_CRMD, 32'h0000_000f);
        w = next_bits(32);
        @(negedge clk);
        exception = 1'b1;
        wen_era = 1'b1;
        era_in = w;
        wen_expcode = 1'b1;
        expcode_in = {1'b1, ECODE_ADE};
        @(negedge clk);
        exception = 1'b0;
        wen_era = 1'b0;
        wen_expcode = 1'b0;
        #5;
        check_val("crmd", 32'h0000_0008, crmd);
        check_val("era_out", w, era_out);
        check_val("estat.ecode", ECODE_ADE, estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]);
        check_val("estat.esubcode", 1, estat[ESTAT_ESUBCODE]);
        check_reg(ADDR_PRMD, 32'h0000_0007);
        // Interrupt code carries no subcode
        @(negedge clk);
        wen_expcode = 1'b1;
        expcode_in = {1'b1, ECODE_INT};
        @(negedge clk);
        wen_expcode = 1'b0;
        #5;
        check_val("estat.ecode", ECODE_INT, estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]);
        check_val("estat.esubcode", 0, estat[ESTAT_ESUBCODE]);
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        #5;
        check_val("crmd", 32'h0000_000f, crmd);
        finish_test();

        start_test("one-shot timer");
        write_csr(ADDR_CRMD, 32'h0000_0008);
        write_csr(ADDR_ECFG, 32'h1 << ESTAT_TI);
        write_csr(ADDR_TCFG, (TIMER_INIT << TCFG_INITVAL_LO) | (1 << TCFG_EN));
        n = 0;
        while (!estat[ESTAT_TI] && n < TI_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (estat[ESTAT_TI]) else begin
            $display("timer interrupt flag not set within %0d cycles", TI_LIMIT);
            err_cnt++;
        end
        if (estat[ESTAT_TI]) begin
            check_val("ti_edges", 4 * TIMER_INIT + 3, n);
        end
        check_val("cpu_interrupt", 0, cpu_interrupt);
        write_csr(ADDR_CRMD, 32'h0000_000c);
        #5;
        check_val("cpu_interrupt", 1, cpu_interrupt);
        write_csr(ADDR_TICLR, 32'h0000_0001);
        #5;
        check_val("estat.ti", 0, estat[ESTAT_TI]);
        check_val("cpu_interrupt", 0, cpu_interrupt);
        check_reg(ADDR_TVAL, 32'h0);
        check_val("estat.ti", 0, estat[ESTAT_TI]);
        finish_test();

        start_test("hardware interrupt lines");
        hw = next_bits(8);
        if (hw == 8'h00) begin
            hw = 8'h5a;
        end
        @(negedge clk);
        hardware_interrupt = hw;
        #5;
        check_val("estat.hwi", hw, estat[ESTAT_HARD_HI:ESTAT_HARD_LO]);
        check_val("idle_over", 1, idle_over);
        check_val("cpu_interrupt", 0, cpu_interrupt);
        @(negedge clk);
        hardware_interrupt = '0;
        #5;
        check_val("estat.hwi", 0, estat[ESTAT_HARD_HI:ESTAT_HARD_LO]);
        check_val("idle_over", 0, idle_over);
        finish_test();

        $display("tests passed %0d failed %0d, check errors %0d", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- test/csr_tb_assertions.sv
`include "csr_config.svh"

module csr_checks import csr_field_pkg::*; (
    input logic                   clk,
    input logic                   aresetn,
    input logic                   exception,
    input logic                   ertn,
    input logic                   cpu_interrupt,
    input logic [`CSR_DATA_W-1:0] crmd
);

    timeunit 1ns;
    timeprecision 1ps;

    // Translation mode is either direct or paged, never both or neither
    da_pg_legal: assert property (@(posedge clk) disable iff (!aresetn)
        crmd[CRMD_DA] != crmd[CRMD_PG])
        else $error("CRMD DA and PG hold the same value");

    // Trap entry drops to kernel level with interrupts masked
    trap_entry_mode: assert property (@(posedge clk) disable iff (!aresetn)
        exception && !ertn |=>
            crmd[CRMD_PLV_HI:CRMD_PLV_LO] == 2'd0 && !crmd[CRMD_IE])
        else $error("CRMD PLV or IE not cleared after exception");

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[CRMD_IE])
        else $error("cpu_interrupt high while CRMD IE is low");

endmodule

bind csr_top csr_checks u_checks (
    .clk(clk),
    .aresetn(aresetn),
    .exception(exception),
    .ertn(ertn),
    .cpu_interrupt(cpu_interrupt),
    .crmd(crmd)
);

//--- verilog.f
+incdir+rtl
rtl/csr_addr_pkg.sv
rtl/csr_field_pkg.sv
rtl/csr_access_decode.sv
rtl/trap_ctrl.sv
rtl/irq_status.sv
rtl/stable_timer.sv
rtl/save_regs.sv
rtl/csr_top.sv
test/csr_tb_assertions.sv
test/csr_tb.sv
